/* Makefile */
# Verilator build and run for the rv32i core testbench

VERILATOR ?= verilator
TOP       ?= tbCpuCore
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test OK$$"

clean:
	rm -rf $(BUILD_DIR)

/* alu.sv */
// integer alu
// picks operand b, runs the add/sub/shift/logic/compare op and
// evaluates the branch condition on the two register operands
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [31:0]  opA,
    input  logic [31:0]  regB,
    input  logic [31:0]  imm,
    input  rvPkg::ctrl_t ctrl,
    input  logic [2:0]   funct3,
    output logic [31:0]  result,
    output logic         branchTaken
);
    import rvPkg::*;

    logic [31:0] opB;
    logic [4:0]  shamt;
    logic        condMet;

    assign opB   = ctrl.aluSrcImm ? imm : regB;
    assign shamt = opB[4:0]; // rv32 uses low five bits only

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  result = opA + opB;
            aluSub:  result = opA - opB;
            aluSll:  result = opA << shamt;
            aluSlt:  result = {31'b0, $signed(opA) < $signed(opB)};
            aluSltu: result = {31'b0, opA < opB};
            aluXor:  result = opA ^ opB;
            aluSrl:  result = opA >> shamt;
            aluSra:  result = $unsigned($signed(opA) >>> shamt); // keeps sign
            aluOr:   result = opA | opB;
            default: result = opA & opB;
        endcase
    end

    // branch compare always against rs2, never the immediate
    always_comb begin
        case (funct3)
            3'b000:  condMet = (opA == regB);                  // beq
            3'b001:  condMet = (opA != regB);                  // bne
            3'b100:  condMet = ($signed(opA) < $signed(regB));  // blt
            3'b101:  condMet = ($signed(opA) >= $signed(regB)); // bge
            3'b110:  condMet = (opA < regB);                   // bltu
            3'b111:  condMet = (opA >= regB);                  // bgeu
            default: condMet = 1'b0; // not a branch encoding
        endcase
    end

    assign branchTaken = ctrl.branch & condMet;

endmodule

`default_nettype wire

/* controlUnit.sv */
// control unit
// decodes opcode/funct into datapath controls and runs the EXEC/BUS FSM
// that launches memory accesses and retires each instruction
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instrValid,
    input  rvPkg::decodedInstr_t dec,
    input  logic                 illegal,
    output rvPkg::ctrl_t         ctrl,
    output logic                 memStart,
    input  logic                 wbDone,
    output logic                 instrDone
);
    import rvPkg::*;

    typedef enum logic {stExec, stBus} state_t;

    state_t state;
    ctrl_t  rawCtrl; // before illegal masking
    logic   isMem;

    // funct3 to alu op, alt picks sub/sra
    function automatic aluOp_t functOp(input logic [2:0] funct3, input logic alt);
        aluOp_t op;
        case (funct3)
            3'b000:  op = alt ? aluSub : aluAdd;
            3'b001:  op = aluSll;
            3'b010:  op = aluSlt;
            3'b011:  op = aluSltu;
            3'b100:  op = aluXor;
            3'b101:  op = alt ? aluSra : aluSrl;
            3'b110:  op = aluOr;
            default: op = aluAnd;
        endcase
        return op;
    endfunction

    always_comb begin
        rawCtrl       = '0;
        rawCtrl.wbSrc = wbAlu;
        rawCtrl.aluOp = aluAdd; // address adder by default
        case (dec.opcode)
            opLoad: begin
                rawCtrl.aluSrcImm = 1'b1;
                rawCtrl.regWrite  = 1'b1;
                rawCtrl.wbSrc     = wbMem;
                rawCtrl.memRead   = 1'b1;
            end
            opStore: begin
                rawCtrl.aluSrcImm = 1'b1;
                rawCtrl.memWrite  = 1'b1;
            end
            opOpImm: begin
                rawCtrl.aluSrcImm = 1'b1;
                rawCtrl.regWrite  = 1'b1;
                // no subi, funct7 only matters for srai
                rawCtrl.aluOp = functOp(dec.funct3, dec.funct3 == 3'b101 && dec.funct7[5]);
            end
            opOp: begin
                rawCtrl.regWrite = 1'b1;
                rawCtrl.aluOp    = functOp(dec.funct3, dec.funct7[5]);
            end
            opBranch: rawCtrl.branch = 1'b1; // compare done beside the alu
            opJal: begin
                rawCtrl.jump     = 1'b1;
                rawCtrl.regWrite = 1'b1;
                rawCtrl.wbSrc    = wbPcPlus4;
            end
            opJalr: begin
                rawCtrl.jalr      = 1'b1;
                rawCtrl.aluSrcImm = 1'b1; // alu forms rs1+imm target
                rawCtrl.regWrite  = 1'b1;
                rawCtrl.wbSrc     = wbPcPlus4;
            end
            opLui: begin
                rawCtrl.regWrite = 1'b1;
                rawCtrl.wbSrc    = wbImm;
            end
            opAuipc: begin
                rawCtrl.aluSrcImm = 1'b1; // opA is pc here
                rawCtrl.regWrite  = 1'b1;
            end
            default: ;
        endcase
    end

    // illegal op retires as a plain pc+4 with no side effects
    always_comb begin
        ctrl = rawCtrl;
        if (illegal) begin
            ctrl.regWrite = 1'b0;
            ctrl.memRead  = 1'b0;
            ctrl.memWrite = 1'b0;
            ctrl.branch   = 1'b0;
            ctrl.jump     = 1'b0;
            ctrl.jalr     = 1'b0;
        end
    end

    assign isMem     = ctrl.memRead | ctrl.memWrite;
    assign memStart  = (state == stExec) && instrValid && isMem;
    assign instrDone = (state == stExec) ? (instrValid && !isMem) : wbDone; // 0-cycle retire

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stExec;
        end else begin
            case (state)
                stExec: begin
                    if (memStart)
                        state <= stBus;
                end
                default: begin
                    if (wbDone) // ack seen, access over
                        state <= stExec;
                end
            endcase
        end
    end

    // an ack only retires the access this FSM launched
    memRetireOnce: assert property (@(posedge clk) disable iff (rst)
        wbDone |-> (state == stBus))
        else $error("wbDone arrived while no memory access was in progress");

endmodule

`default_nettype wire

/* cpuCore.sv */
// rv32i core top
// pc register, next-pc and write-back selection around decoder,
// control FSM, alu, register file and wishbone load/store unit
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       instruction,
    input  logic              instrValid,
    output logic              instrDone,
    output logic [31:0]       pc,
    output logic [31:0][31:0] regWindow,
    output logic [31:0]       aluResult,
    output logic              illegal,
    output rvPkg::wbReq_t     wbReq,
    input  rvPkg::wbRsp_t     wbRsp
);
    import rvPkg::*;

    decodedInstr_t dec;
    ctrl_t         ctrl;
    logic          memStart;
    logic          wbDone;
    logic          branchTaken;
    logic          regWe;
    logic [31:0]   rdata1;
    logic [31:0]   rdata2;
    logic [31:0]   opA;
    logic [31:0]   loadData;
    logic [31:0]   wbData;
    logic [31:0]   pcPlus4;
    logic [31:0]   nextPc;

    instrDecoder decoder (
        .instruction(instruction),
        .dec(dec),
        .illegal(illegal)
    );

    controlUnit ctrlUnit (
        .clk(clk),
        .rst(rst),
        .instrValid(instrValid),
        .dec(dec),
        .illegal(illegal),
        .ctrl(ctrl),
        .memStart(memStart),
        .wbDone(wbDone),
        .instrDone(instrDone)
    );

    alu aluUnit (
        .opA(opA),
        .regB(rdata2),
        .imm(dec.imm),
        .ctrl(ctrl),
        .funct3(dec.funct3),
        .result(aluResult), // also the load/store address
        .branchTaken(branchTaken)
    );

    registerFile regs (
        .clk(clk),
        .rst(rst),
        .rs1(dec.rs1),
        .rs2(dec.rs2),
        .rd(dec.rd),
        .we(regWe),
        .wdata(wbData),
        .rdata1(rdata1),
        .rdata2(rdata2),
        .regWindow(regWindow)
    );

    memHandler lsu (
        .clk(clk),
        .rst(rst),
        .memStart(memStart),
        .ctrl(ctrl),
        .funct3(dec.funct3),
        .addr(aluResult),
        .storeData(rdata2),
        .wbReq(wbReq),
        .wbRsp(wbRsp),
        .wbDone(wbDone),
        .loadData(loadData)
    );

    assign opA     = (dec.opcode == opAuipc) ? pc : rdata1;
    assign pcPlus4 = pc + 32'd4;
    assign regWe   = ctrl.regWrite & instrDone; // write lands on the retire edge

    always_comb begin
        case (ctrl.wbSrc)
            wbImm:     wbData = dec.imm;  // lui
            wbMem:     wbData = loadData;
            wbPcPlus4: wbData = pcPlus4;  // link address
            default:   wbData = aluResult;
        endcase
    end

    always_comb begin
        if (ctrl.jalr)
            nextPc = {aluResult[31:1], 1'b0};
        else if (ctrl.jump || branchTaken)
            nextPc = pc + dec.imm;
        else
            nextPc = pcPlus4;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= resetPc;
        end else if (instrDone) begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

/* instrDecoder.sv */
// rv32i instruction decoder
// splits out register and function fields, builds the immediate for
// the opcode's format and flags opcodes the core does not implement
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  logic [31:0]          instruction,
    output rvPkg::decodedInstr_t dec,
    output logic                 illegal
);
    import rvPkg::*;

    logic [6:0]  opcode;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;

    assign opcode = instruction[6:0];

    // every format takes its sign from bit 31
    assign immI = {{20{instruction[31]}}, instruction[31:20]};
    assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};     // halfword offset
    assign immU = {instruction[31:12], 12'b0};
    assign immJ = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                   instruction[20], instruction[30:21], 1'b0};

    always_comb begin
        dec.rs1    = instruction[19:15];
        dec.rs2    = instruction[24:20];
        dec.rd     = instruction[11:7];
        dec.opcode = opcode;
        dec.funct3 = instruction[14:12];
        dec.funct7 = instruction[31:25]; // sub/sra select, also imm bits for i-type
        illegal    = 1'b0;
        case (opcode)
            opLoad, opOpImm, opJalr: dec.imm = immI;
            opStore:                 dec.imm = immS;
            opBranch:                dec.imm = immB;
            opLui, opAuipc:          dec.imm = immU;
            opJal:                   dec.imm = immJ;
            opOp:                    dec.imm = '0; // r-type
            default: begin
                // fence, system and anything unknown
                dec.imm = '0;
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* memHandler.sv */
// load/store unit, wishbone classic master
// latches address, byte lanes and shifted store data on memStart,
// holds the cycle until ack and aligns/extends the returned load data
`timescale 1ns/1ps
`default_nettype none

module memHandler (
    input  logic          clk,
    input  logic          rst,
    input  logic          memStart,
    input  rvPkg::ctrl_t  ctrl,
    input  logic [2:0]    funct3,
    input  logic [31:0]   addr,
    input  logic [31:0]   storeData,
    output rvPkg::wbReq_t wbReq,
    input  rvPkg::wbRsp_t wbRsp,
    output logic          wbDone,
    output logic [31:0]   loadData
);

    logic        reqCyc;
    logic        reqStb;
    logic        reqWe;
    logic [3:0]  reqSel;
    logic [31:0] reqAdr;
    logic [31:0] reqDat;
    logic [3:0]  selNext;
    logic [31:0] datNext;
    logic [31:0] rdShifted;

    // byte enables from size and low address bits
    always_comb begin
        case (funct3[1:0])
            2'b00:   selNext = 4'b0001 << addr[1:0];
            2'b01:   selNext = 4'b0011 << addr[1:0]; // halfword, addr[0] assumed 0
            default: selNext = 4'b1111;
        endcase
    end

    assign datNext = storeData << {addr[1:0], 3'b000}; // move low bytes onto their lane

    always_ff @(posedge clk) begin
        if (rst) begin
            reqCyc <= 1'b0;
            reqStb <= 1'b0;
            reqWe  <= 1'b0;
        end else if (memStart) begin
            reqCyc <= 1'b1;
            reqStb <= 1'b1;
            reqWe  <= ctrl.memWrite;
        end else if (wbDone) begin
            reqCyc <= 1'b0;
            reqStb <= 1'b0;
            reqWe  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (memStart) begin
            reqAdr <= addr;
            reqSel <= selNext;
            reqDat <= datNext;
        end
    end

    assign wbReq  = '{cyc: reqCyc, stb: reqStb, we: reqWe, sel: reqSel,
                      adr: reqAdr, datW: reqDat};
    assign wbDone = reqCyc & wbRsp.ack;

    assign rdShifted = wbRsp.datR >> {reqAdr[1:0], 3'b000};

    always_comb begin
        case (funct3)
            3'b000:  loadData = {{24{rdShifted[7]}}, rdShifted[7:0]};   // lb
            3'b001:  loadData = {{16{rdShifted[15]}}, rdShifted[15:0]}; // lh
            3'b100:  loadData = {24'b0, rdShifted[7:0]};                // lbu
            3'b101:  loadData = {16'b0, rdShifted[15:0]};               // lhu
            default: loadData = rdShifted;                              // lw
        endcase
    end

    stbInCyc: assert property (@(posedge clk) disable iff (rst) wbReq.stb |-> wbReq.cyc)
        else $error("stb asserted outside a bus cycle");

    // no new access may be launched while one is waiting for ack
    reqStable: assert property (@(posedge clk) disable iff (rst)
        (wbReq.stb && !wbRsp.ack) |=> ($stable(wbReq.adr) && $stable(wbReq.sel)))
        else $error("address or byte select changed during a pending access");

endmodule

`default_nettype wire

/* project.f */
rvPkg.sv
instrDecoder.sv
controlUnit.sv
alu.sv
registerFile.sv
memHandler.sv
cpuCore.sv
tbChecker.sv
tbCpuCore.sv

/* registerFile.sv */
// rv32i register file
// 32 x 32 bits, two async read ports, one sync write port,
// x0 hardwired to zero, whole array visible on a window port
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic              clk,
    input  logic              rst,
    input  logic [4:0]        rs1,
    input  logic [4:0]        rs2,
    input  logic [4:0]        rd,
    input  logic              we,
    input  logic [31:0]       wdata,
    output logic [31:0]       rdata1,
    output logic [31:0]       rdata2,
    output logic [31:0][31:0] regWindow
);

    logic [31:0][31:0] regs;

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '0; // architectural state starts at zero
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1    = regs[rs1];
    assign rdata2    = regs[rs2];
    assign regWindow = regs; // observation only

    x0Zero: assert property (@(posedge clk) disable iff (rst) regs[0] == 32'd0)
        else $error("x0 holds a nonzero value");

endmodule

`default_nettype wire

/* rvPkg.sv */
// rv32i core shared definitions
// opcodes, alu and write-back encodings, control and decode bundles,
// wishbone classic request/response bundles and the reset pc
`default_nettype none

package rvPkg;

    // major opcodes, instruction[6:0]
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;

    localparam logic [31:0] resetPc = 32'h0000_0000; // first instruction address

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu,
        aluXor, aluSrl, aluSra, aluOr, aluAnd
    } aluOp_t;

    typedef enum logic [1:0] {
        wbAlu, wbImm, wbMem, wbPcPlus4
    } wbSrc_t; // register write-back source

    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [31:0] imm;    // already sign-extended
    } decodedInstr_t;

    typedef struct packed {
        logic   aluSrcImm; // operand b from imm
        logic   regWrite;
        wbSrc_t wbSrc;
        logic   branch;
        logic   jump;      // jal
        logic   jalr;
        logic   memRead;
        logic   memWrite;
        aluOp_t aluOp;
    } ctrl_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;  // byte lanes
        logic [31:0] adr;  // byte address
        logic [31:0] datW;
    } wbReq_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] datR;
    } wbRsp_t;

endpackage

`default_nettype wire

/* tbChecker.sv */
// retirement checker for the rv32i core
// keeps a shadow of the expected registers, compares pc, registers,
// illegal flag, load/store address and stored memory words, and
// watches bus request stability
`timescale 1ns/1ps
`default_nettype none

module tbChecker (
    input  logic              clk,
    input  logic              rst,
    input  logic              instrDone,
    input  logic              illegal,
    input  logic [31:0]       pc,
    input  logic [31:0][31:0] regWindow,
    input  logic [31:0]       aluResult,
    input  rvPkg::wbReq_t     wbReq,
    input  rvPkg::wbRsp_t     wbRsp,
    input  logic [63:0][31:0] mem,
    input  logic [4:0]        expRd,
    input  logic [31:0]       expVal,
    input  logic [31:0]       expPc,
    input  logic              expIll,
    input  logic              memChk,
    input  logic [5:0]        memIdx,
    input  logic [31:0]       memWord,
    input  logic              adrChk,
    input  logic [31:0]       expAdr,
    output int                errCount,
    output int                checkCount
);
    import rvPkg::*;

    logic [31:0][31:0] shadow; // registers as they should be
    logic              pending;  // a retirement edge just passed
    logic              illSeen;
    logic              illExp;
    logic [31:0]       pcExp;
    logic              chkMem;
    logic [5:0]        idxExp;
    logic [31:0]       wordExp;
    logic [31:0]       aluSeen;
    logic              chkAdr;
    logic [31:0]       adrExp;
    logic              busPending;
    logic [31:0]       adrHeld;
    logic [3:0]        selHeld;

    // capture the entry on the retire edge, dut state settles after it
    always @(posedge clk) begin
        if (rst) begin
            pending    <= 1'b0;
            shadow     <= '0;
            checkCount <= 0;
        end else begin
            pending <= instrDone;
            if (instrDone) begin
                checkCount <= checkCount + 1;
                illSeen    <= illegal; // flag only valid in the retire cycle
                illExp     <= expIll;
                pcExp      <= expPc;
                chkMem     <= memChk;
                idxExp     <= memIdx;
                wordExp    <= memWord;
                aluSeen    <= aluResult; // address of a load or store
                chkAdr     <= adrChk;
                adrExp     <= expAdr;
                if (expRd != 5'd0)
                    shadow[expRd] <= expVal;
            end
        end
    end

    always @(negedge clk) begin
        if (pending) begin
            if (illSeen !== illExp) begin
                $display("Error at %0t: illegal is %b, expected %b", $time, illSeen, illExp);
                errCount++;
            end
            if (pc !== pcExp) begin
                $display("Error at %0t: pc is %h, expected %h", $time, pc, pcExp);
                errCount++;
            end
            if (chkAdr && aluSeen !== adrExp) begin
                $display("Error at %0t: access address is %h, expected %h", $time,
                         aluSeen, adrExp);
                errCount++;
            end
            // whole file, so stray writes show up too
            for (int r = 0; r < 32; r++) begin
                if (regWindow[5'(r)] !== shadow[5'(r)]) begin
                    $display("Error at %0t: x%0d is %h, expected %h", $time, r,
                             regWindow[5'(r)], shadow[5'(r)]);
                    errCount++;
                end
            end
            if (chkMem && mem[idxExp] !== wordExp) begin
                $display("Error at %0t: mem word %0d is %h, expected %h", $time, idxExp,
                         mem[idxExp], wordExp);
                errCount++;
            end
        end
        // adr and sel must hold while stb waits for ack
        if (!rst && busPending && wbReq.stb &&
            (wbReq.adr !== adrHeld || wbReq.sel !== selHeld)) begin
            $display("Error at %0t: adr/sel changed from %h/%b to %h/%b before ack", $time,
                     adrHeld, selHeld, wbReq.adr, wbReq.sel);
            errCount++;
        end
        busPending = !rst && wbReq.stb && !wbRsp.ack;
        adrHeld    = wbReq.adr;
        selHeld    = wbReq.sel;
    end

endmodule

`default_nettype wire

/* tbCpuCore.sv */
// testbench top for the rv32i core
// applies an instruction table, models a wishbone slave memory with
// random wait states and bounds the run with a watchdog
`timescale 1ns/1ps
`default_nettype none

module tbCpuCore;
    import rvPkg::*;

    localparam int numCases  = 40;
    localparam int clkPeriod = 40; // ns

    typedef struct packed {
        logic [31:0] instr;
        logic [4:0]  rd;      // 0 when nothing is written
        logic [31:0] val;
        logic [31:0] nextPc;
        logic        ill;
        logic        memChk;  // store, check the word below
        logic [5:0]  memIdx;
        logic [31:0] memWord;
        logic        adrChk;  // load or store, check the address below
        logic [31:0] adr;
    } case_t;

    logic              clk;
    logic              rst;
    logic [31:0]       instruction;
    logic              instrValid;
    logic              instrDone;
    logic [31:0]       pc;
    logic [31:0][31:0] regWindow;
    logic [31:0]       aluResult;
    logic              illegal;
    wbReq_t            wbReq;
    wbRsp_t            wbRsp;
    logic [63:0][31:0] mem;      // slave memory, 256 bytes
    logic [31:0]       rng;
    logic [1:0]        waitLeft;
    logic              busy;
    case_t             tbl [numCases];
    case_t             exp;
    logic [5:0]        cur;
    int                n;
    int                errCount;
    int                checkCount;

    cpuCore dut_i (
        .clk(clk), .rst(rst), .instruction(instruction), .instrValid(instrValid),
        .instrDone(instrDone), .pc(pc), .regWindow(regWindow), .aluResult(aluResult),
        .illegal(illegal), .wbReq(wbReq), .wbRsp(wbRsp)
    );

    assign exp = tbl[cur];

    tbChecker chk (
        .clk(clk), .rst(rst), .instrDone(instrDone), .illegal(illegal), .pc(pc),
        .regWindow(regWindow), .aluResult(aluResult), .wbReq(wbReq), .wbRsp(wbRsp),
        .mem(mem), .expRd(exp.rd), .expVal(exp.val), .expPc(exp.nextPc),
        .expIll(exp.ill), .memChk(exp.memChk), .memIdx(exp.memIdx),
        .memWord(exp.memWord), .adrChk(exp.adrChk), .expAdr(exp.adr),
        .errCount(errCount), .checkCount(checkCount)
    );

    // instruction encoders, field order as in the isa manual
    function automatic logic [31:0] rType(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opOp};
    endfunction

    function automatic logic [31:0] iType(input int imm, input int rs1, input int f3,
                                          input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] sType(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] bType(input int off, input int rs2, input int rs1,
                                          input int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], opBranch};
    endfunction

    function automatic logic [31:0] uType(input int imm20, input int rd, input logic [6:0] op);
        return {imm20[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] jType(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], opJal};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic regCase(input logic [31:0] instr, input int rd, input logic [31:0] val,
                           input logic [31:0] nextPc);
        tbl[6'(n)] = '{instr: instr, rd: 5'(rd), val: val, nextPc: nextPc, ill: 1'b0,
                       memChk: 1'b0, memIdx: 6'd0, memWord: 32'd0,
                       adrChk: 1'b0, adr: 32'd0};
        n++;
    endtask

    task automatic loadCase(input logic [31:0] instr, input logic [31:0] adr, input int rd,
                            input logic [31:0] val, input logic [31:0] nextPc);
        tbl[6'(n)] = '{instr: instr, rd: 5'(rd), val: val, nextPc: nextPc, ill: 1'b0,
                       memChk: 1'b0, memIdx: 6'd0, memWord: 32'd0,
                       adrChk: 1'b1, adr: adr};
        n++;
    endtask

    task automatic storeCase(input logic [31:0] instr, input logic [31:0] adr, input int idx,
                             input logic [31:0] word, input logic [31:0] nextPc);
        tbl[6'(n)] = '{instr: instr, rd: 5'd0, val: 32'd0, nextPc: nextPc, ill: 1'b0,
                       memChk: 1'b1, memIdx: 6'(idx), memWord: word,
                       adrChk: 1'b1, adr: adr};
        n++;
    endtask

    task automatic illegalCase(input logic [31:0] instr, input logic [31:0] nextPc);
        tbl[6'(n)] = '{instr: instr, rd: 5'd0, val: 32'd0, nextPc: nextPc, ill: 1'b1,
                       memChk: 1'b0, memIdx: 6'd0, memWord: 32'd0,
                       adrChk: 1'b0, adr: 32'd0};
        n++;
    endtask

    task automatic loadProgram();
        n = 0;
        regCase(iType(5, 0, 0, 1, opOpImm), 1, 5, 32'h04);                 // addi x1
        regCase(iType(-3, 0, 0, 2, opOpImm), 2, -3, 32'h08);               // addi x2
        regCase(rType(0, 2, 1, 0, 3), 3, 2, 32'h0C);                       // add
        regCase(rType(32, 2, 1, 0, 4), 4, 8, 32'h10);                      // sub
        regCase(rType(0, 1, 2, 2, 5), 5, 1, 32'h14);                       // slt -3<5
        regCase(rType(0, 1, 2, 3, 6), 6, 0, 32'h18);                       // sltu
        regCase(iType(32'hF0, 1, 4, 7, opOpImm), 7, 32'hF5, 32'h1C);       // xori
        regCase(rType(0, 2, 1, 6, 8), 8, 32'hFFFF_FFFD, 32'h20);           // or
        regCase(iType(32'hFF, 2, 7, 9, opOpImm), 9, 32'hFD, 32'h24);       // andi
        regCase(iType(4, 1, 1, 10, opOpImm), 10, 32'h50, 32'h28);          // slli
        regCase(iType(32'h401, 2, 5, 11, opOpImm), 11, 32'hFFFF_FFFE, 32'h2C); // srai
        regCase(iType(28, 2, 5, 12, opOpImm), 12, 32'hF, 32'h30);          // srli
        regCase(rType(32, 1, 2, 5, 13), 13, 32'hFFFF_FFFF, 32'h34);        // sra -3 by 5
        regCase(uType(32'h12345, 14, opLui), 14, 32'h1234_5000, 32'h38);
        regCase(uType(1, 15, opAuipc), 15, 32'h1038, 32'h3C);
        regCase(iType(7, 1, 0, 0, opOpImm), 0, 0, 32'h40);                 // x0 stays 0
        regCase(iType(32'h40, 0, 0, 16, opOpImm), 16, 32'h40, 32'h44);     // base word 16
        regCase(uType(32'h89ABD, 17, opLui), 17, 32'h89AB_D000, 32'h48);
        regCase(iType(-529, 17, 0, 17, opOpImm), 17, 32'h89AB_CDEF, 32'h4C);
        storeCase(sType(0, 17, 16, 2), 32'h40, 16, 32'h89AB_CDEF, 32'h50);     // sw
        storeCase(sType(6, 2, 16, 1), 32'h46, 17, 32'hFFFD_0044, 32'h54);      // sh upper half
        storeCase(sType(9, 1, 16, 0), 32'h49, 18, 32'hDEAD_0548, 32'h58);      // sb lane 1
        loadCase(iType(0, 16, 2, 18, opLoad), 32'h40, 18, 32'h89AB_CDEF, 32'h5C); // lw
        loadCase(iType(6, 16, 1, 19, opLoad), 32'h46, 19, 32'hFFFF_FFFD, 32'h60); // lh
        loadCase(iType(6, 16, 5, 20, opLoad), 32'h46, 20, 32'h0000_FFFD, 32'h64); // lhu
        loadCase(iType(3, 16, 0, 21, opLoad), 32'h43, 21, 32'hFFFF_FF89, 32'h68); // lb
        loadCase(iType(1, 16, 4, 22, opLoad), 32'h41, 22, 32'hCD, 32'h6C);        // lbu
        loadCase(iType(9, 16, 0, 23, opLoad), 32'h49, 23, 32'h05, 32'h70);        // lb
        regCase(bType(8, 1, 1, 0), 0, 0, 32'h78);                          // beq taken
        regCase(bType(8, 1, 1, 1), 0, 0, 32'h7C);                          // bne not
        regCase(bType(12, 1, 2, 4), 0, 0, 32'h88);                         // blt taken
        regCase(bType(8, 1, 2, 5), 0, 0, 32'h8C);                          // bge not
        regCase(bType(16, 2, 1, 6), 0, 0, 32'h9C);                         // bltu taken
        regCase(bType(8, 1, 2, 7), 0, 0, 32'hA4);                          // bgeu taken
        regCase(bType(8, 2, 1, 0), 0, 0, 32'hA8);                          // beq not
        regCase(jType(20, 24), 24, 32'hAC, 32'hBC);                        // jal
        regCase(iType(32'h13, 16, 0, 25, opJalr), 25, 32'hC0, 32'h52);     // bit 0 dropped
        illegalCase(32'h0000_000F, 32'h56);                                // fence
        illegalCase(32'hFFFF_FFFF, 32'h5A);                                // rd field x31
        regCase(iType(1, 1, 0, 26, opOpImm), 26, 6, 32'h5E);
    endtask

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // wishbone slave, 2 to 5 cycles from stb to ack
    initial begin
        logic [31:0] nxt;
        logic [31:0] mask;
        logic [5:0]  idx;
        wbRsp    = '0;
        busy     = 1'b0;
        waitLeft = '0;
        rng      = 32'd79;
        for (int i = 0; i < 64; i++)
            mem[6'(i)] = 32'hDEAD_0000 | (i << 2); // byte address in the low half
        forever begin
            @(posedge clk);
            nxt  = xorshift32(rng);
            idx  = wbReq.adr[7:2];
            mask = {{8{wbReq.sel[3]}}, {8{wbReq.sel[2]}}, {8{wbReq.sel[1]}}, {8{wbReq.sel[0]}}};
            if (wbRsp.ack) begin
                wbRsp.ack <= 1'b0; // single-cycle ack
            end else if (!rst && wbReq.cyc && wbReq.stb) begin
                if (!busy) begin
                    busy     <= 1'b1;
                    rng      <= nxt;
                    waitLeft <= nxt[1:0];
                end else if (waitLeft != 2'd0) begin
                    waitLeft <= waitLeft - 2'd1;
                end else begin
                    busy       <= 1'b0;
                    wbRsp.ack  <= 1'b1;
                    wbRsp.datR <= mem[idx];
                    if (wbReq.we)
                        mem[idx] <= (mem[idx] & ~mask) | (wbReq.datW & mask);
                end
            end
        end
    end

    initial begin
        loadProgram();
        rst         = 1'b1;
        instrValid  = 1'b0;
        instruction = '0;
        cur         = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < numCases; i++) begin
            cur         <= 6'(i);
            instruction <= tbl[6'(i)].instr;
            instrValid  <= 1'b1;
            @(posedge clk);
            while (!instrDone) // hold until retired
                @(posedge clk);
        end
        instrValid <= 1'b0;
        @(posedge clk); // let the last compare run
        $display("checks %0d of %0d, errors %0d", checkCount, numCases, errCount);
        if (errCount == 0 && checkCount == numCases) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // generous bound, loads take at most seven cycles
    initial begin
        #(numCases * 10 * clkPeriod);
        $display("timeout: the core stopped retiring instructions before the table ended");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire
